/* channelDiscriminator.sv */
`timescale 1ns/10ps

module channelDiscriminator import oscTrigPkg::*; #(
	parameter int totWidth = 10
) (
	input logic clk_flash,
	input logic trigratecountreset,
	input sample_t sampleReg,
	input trigCfg_t cfg,
	input logic strobe,
	output logic fire
);

	logic inWin; // sample inside the window, one cycle after sampleReg
	logic prevWin; // inWin one cycle later
	logic edgeHit; // selected window edge seen this cycle
	logic armedLvl; // channel is in the state the tot qualifier watches
	logic [totWidth-1:0] totQ; // active part of the tot field
	logic [totWidth:0] totCnt; // persistence counter, zero when idle
	logic advance; // counter may move this cycle

	assign totQ = cfg.tot[totWidth-1:0];
	assign armedLvl = cfg.rising ? inWin : ~inWin; // inside for rising, outside for falling
	assign edgeHit = cfg.rising ? (inWin & ~prevWin) : (~inWin & prevWin);
	assign advance = !cfg.totOnStrobe || strobe; // every clock, or only on strobes

	always_ff @(posedge clk_flash) begin
		if (trigratecountreset) begin
			inWin <= 1'b0;
			prevWin <= 1'b0;
		end else begin
			inWin <= (sampleReg >= cfg.threshLo) && (sampleReg <= cfg.threshHi);
			prevWin <= inWin;
		end
	end

	always_ff @(posedge clk_flash) begin
		if (trigratecountreset) begin
			fire <= 1'b0;
			totCnt <= '0;
		end else if (totQ == '0) begin
			fire <= edgeHit; // plain edge trigger
			totCnt <= '0;
		end else begin
			fire <= 1'b0; // default, pulses below
			if (totCnt != '0) begin
				if (totCnt > {1'b0, totQ}) begin
					fire <= 1'b1; // held long enough
					totCnt <= '0;
				end else if (advance) begin
					if (armedLvl) totCnt <= totCnt + 1'b1; // still armed
					else totCnt <= '0; // dropped out early, give up
				end
			end else if (edgeHit) begin
				totCnt <= 1; // start counting from the edge
			end
		end
	end

endmodule

/* coincidenceTrigger.sv */
`timescale 1ns/10ps

module coincidenceTrigger import oscTrigPkg::*; (
	input logic clk_flash,
	input logic trigratecountreset,
	input logic [numCh-1:0] fire,
	input trigCfg_t cfg,
	input logic strobe,
	output logic selfEdgeTrig
);

	localparam int cntW = $clog2(numCh + 1); // holds 0 to numCh

	logic [holdW-1:0] hold [numCh]; // per channel hold countdown
	logic [numCh-1:0] openWin; // enabled channel with its hold window open
	logic [cntW-1:0] openCnt [numCh]; // open windows seen by each channel

	always_ff @(posedge clk_flash) begin
		if (trigratecountreset) begin
			for (int i = 0; i < numCh; i++) hold[i] <= '0;
		end else begin
			for (int i = 0; i < numCh; i++) begin
				if (fire[i]) hold[i] <= cfg.holdTime; // reopen on every fire
				else if (hold[i] != '0 && strobe) hold[i] <= hold[i] - 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < numCh; i++) openWin[i] = cfg.chanEn[i] && (hold[i] != '0);
	end

	// windows still reflect earlier fires, a fire this cycle is not yet loaded
	always_comb begin
		selfEdgeTrig = 1'b0;
		for (int i = 0; i < numCh; i++) begin
			openCnt[i] = '0;
			for (int j = 0; j < numCh; j++) begin
				if (j != i || cfg.allowSameChan) openCnt[i] = openCnt[i] + cntW'(openWin[j]);
			end
			if (cfg.chanEn[i] && fire[i] && openCnt[i] >= cntW'(cfg.coincReq))
				selfEdgeTrig = 1'b1; // or across enabled firing channels
		end
	end

endmodule

/* oscTrigPkg.sv */
package oscTrigPkg;

	localparam int numCh = 4; // adc channels on the board
	localparam int sampleW = 8; // flash adc sample width
	localparam int holdW = 8; // hold time and dead time counters
	localparam int dsW = 5; // downsample exponent width
	localparam int maxDownsample = 22; // largest exponent the strobe honours
	localparam int wbAdrW = 3; // wishbone word address
	localparam int wbDatW = 32; // wishbone data bus
	localparam int totMax = 10; // storage width of the tot field

	// register word addresses
	localparam logic [wbAdrW-1:0] regThresh = 3'd0; // lo in 7..0, hi in 15..8
	localparam logic [wbAdrW-1:0] regCtrl = 3'd1; // enables, edge, coincidence, downsample
	localparam logic [wbAdrW-1:0] regTot = 3'd2; // tot count, bit 31 is totOnStrobe
	localparam logic [wbAdrW-1:0] regHold = 3'd3; // hold time
	localparam logic [wbAdrW-1:0] regRate = 3'd4; // rate counter, read only

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [wbAdrW-1:0] adr;
		logic [wbDatW-1:0] dat;
	} wbReq_t; // master to slave

	typedef struct packed {
		logic ack;
		logic [wbDatW-1:0] dat;
	} wbResp_t; // slave to master

	typedef struct packed {
		logic [sampleW-1:0] threshLo; // window bottom, inclusive
		logic [sampleW-1:0] threshHi; // window top, inclusive
		logic [numCh-1:0] chanEn; // channels that may self trigger
		logic rising; // 1 fires on window entry, 0 on exit
		logic [1:0] coincReq; // open windows needed besides the firing one
		logic allowSameChan; // own open window counts toward coincidence
		logic [dsW-1:0] downsample; // strobe exponent
		logic [totMax-1:0] tot; // time over threshold, 0 disables
		logic totOnStrobe; // tot counts strobes instead of clocks
		logic [holdW-1:0] holdTime; // hold window and dead time length
	} trigCfg_t;

	typedef logic [sampleW-1:0] sample_t;
	typedef sample_t [numCh-1:0] sampleVec_t; // one sample per channel

endpackage

/* oscTrigTop.f */
oscTrigPkg.sv
trigConfigRegs.sv
sampleStrobe.sv
channelDiscriminator.sv
coincidenceTrigger.sv
trigRateCounter.sv
oscTrigTop.sv
tb_oscTrigTop.sv

/* oscTrigTop.sv */
`timescale 1ns/10ps

module oscTrigTop import oscTrigPkg::*; #(
	parameter int totWidth = 10, // at most totMax
	parameter int rateWidth = 32 // at most wbDatW
) (
	input logic clk_flash,
	input logic trigratecountreset,
	input sampleVec_t samples,
	input wbReq_t wbIn,
	output wbResp_t wbOut,
	output logic selfEdgeTrig,
	output logic [numCh-1:0] chanFire,
	output logic [rateWidth-1:0] trigRate
);

	sampleVec_t sampleReg; // adc pins captured once per clock
	trigCfg_t cfg; // configuration fanned out to every block
	logic strobe; // downsample pacing
	logic [rateWidth-1:0] rateCount;

	always_ff @(posedge clk_flash) begin
		if (trigratecountreset) sampleReg <= '0;
		else sampleReg <= samples;
	end

	trigConfigRegs #(.totWidth(totWidth), .rateWidth(rateWidth)) u_trigConfigRegs (
		.clk_flash(clk_flash), .trigratecountreset(trigratecountreset),
		.wbIn(wbIn), .wbOut(wbOut), .rateCount(rateCount), .cfg(cfg)
	);

	sampleStrobe u_sampleStrobe (
		.clk_flash(clk_flash), .trigratecountreset(trigratecountreset),
		.downsample(cfg.downsample), .strobe(strobe)
	);

	for (genvar i = 0; i < numCh; i++) begin : g_chan
		channelDiscriminator #(.totWidth(totWidth)) u_chanDisc (
			.clk_flash(clk_flash), .trigratecountreset(trigratecountreset),
			.sampleReg(sampleReg[i]), .cfg(cfg), .strobe(strobe), .fire(chanFire[i])
		);
	end

	coincidenceTrigger u_coincidenceTrigger (
		.clk_flash(clk_flash), .trigratecountreset(trigratecountreset),
		.fire(chanFire), .cfg(cfg), .strobe(strobe), .selfEdgeTrig(selfEdgeTrig)
	);

	trigRateCounter #(.rateWidth(rateWidth)) u_trigRateCounter (
		.clk_flash(clk_flash), .trigratecountreset(trigratecountreset),
		.selfEdgeTrig(selfEdgeTrig), .holdTime(cfg.holdTime), .strobe(strobe),
		.rateCount(rateCount)
	);

	assign trigRate = rateCount; // brought out for observation

endmodule

/* sampleStrobe.sv */
`timescale 1ns/10ps

module sampleStrobe import oscTrigPkg::*; (
	input logic clk_flash,
	input logic trigratecountreset,
	input logic [dsW-1:0] downsample,
	output logic strobe
);

	logic [maxDownsample-1:0] cnt; // free running sample counter
	logic [maxDownsample-1:0] mask; // low bits that must all be set
	logic [dsW-1:0] dsLim; // exponent clipped to the counter range

	assign dsLim = (downsample > dsW'(maxDownsample)) ? dsW'(maxDownsample) : downsample;
	assign mask = (maxDownsample'(1) << dsLim) - 1'b1; // wraps to all ones at the limit

	always_ff @(posedge clk_flash) begin
		if (trigratecountreset) cnt <= '0;
		else cnt <= cnt + 1'b1;
	end

	// one strobe per 2^dsLim clocks, every clock when the mask is empty
	assign strobe = &(cnt | ~mask);

endmodule

/* tb_oscTrigTop.sv */
`timescale 1ns/10ps

module tb_oscTrigTop import oscTrigPkg::*;;

	localparam int totWidth = 10;
	localparam int rateWidth = 32;
	localparam int loT = 100; // window used by every test
	localparam int hiT = 150;
	localparam int cycleLimit = 6000; // tests need well under 4000 cycles

	logic clk_flash;
	logic trigratecountreset;
	sampleVec_t samples;
	wbReq_t wbIn;
	wbResp_t wbOut;
	logic selfEdgeTrig;
	logic [numCh-1:0] chanFire;
	logic [rateWidth-1:0] trigRate;

	int unsigned seedVar;
	int cycles = 0;
	logic [wbDatW-1:0] rdData; // data of the last bus cycle

	// reference state advanced once per rising edge
	trigCfg_t cfgM;
	logic ackM = 1'b0;
	int cntM = 0; // strobe phase counter
	sampleVec_t sregM = '0;
	logic [numCh-1:0] inWinM = '0;
	logic [numCh-1:0] prevWinM = '0;
	logic [numCh-1:0] fireM = '0;
	int totCntM [numCh];
	int holdM [numCh];
	logic selfM = 1'b0;
	logic [rateWidth-1:0] rateM = '0;
	int deadM = 0;

	oscTrigTop #(.totWidth(totWidth), .rateWidth(rateWidth)) u_oscTrigTop (
		.clk_flash(clk_flash), .trigratecountreset(trigratecountreset), .samples(samples),
		.wbIn(wbIn), .wbOut(wbOut), .selfEdgeTrig(selfEdgeTrig), .chanFire(chanFire),
		.trigRate(trigRate)
	);

	always #2 clk_flash = ~clk_flash; // 4 ns period

	task automatic stopOnError(input string line);
		$display("%s", line);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// one cycle in 2^ds on the last count of each period
	function automatic logic refStrobe(input int count, input logic [dsW-1:0] ds);
		int period;
		period = 1 << ((ds > maxDownsample) ? maxDownsample : ds);
		return (count % period) == period - 1;
	endfunction

	// expected fire of one channel at the next edge with count as its tot counter
	function automatic logic refFire(input trigCfg_t c, input logic win, input logic lastWin,
		input logic stb, inout int count);
		logic crossed;
		logic stay;
		crossed = c.rising ? (win && !lastWin) : (!win && lastWin);
		stay = c.rising ? win : !win; // armed level
		if (c.tot == 0) begin
			count = 0;
			return crossed; // plain edge
		end
		if (count == 0) begin
			if (crossed) count = 1; // edge arms the counter
			return 1'b0;
		end
		if (count > c.tot) begin
			count = 0;
			return 1'b1; // qualified span ends here
		end
		if (!c.totOnStrobe || stb) count = stay ? count + 1 : 0;
		return 1'b0;
	endfunction

	// coincidence of enabled firing channels with open windows
	function automatic logic refSelfTrig(input logic [numCh-1:0] f, input logic [numCh-1:0] held,
		input trigCfg_t c);
		int seen;
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < numCh; i++) begin
			seen = 0;
			for (int j = 0; j < numCh; j++)
				if (c.chanEn[j] && held[j] && (i != j || c.allowSameChan)) seen++;
			if (c.chanEn[i] && f[i] && seen >= c.coincReq) hit = 1'b1;
		end
		return hit;
	endfunction

	task automatic stepModel();
		logic stb;
		logic access;
		logic [numCh-1:0] fireNext;
		logic [numCh-1:0] held;
		if (trigratecountreset) begin
			cfgM = '0;
			ackM = 1'b0;
			cntM = 0;
			sregM = '0;
			inWinM = '0;
			prevWinM = '0;
			fireM = '0;
			rateM = '0;
			deadM = 0;
			for (int i = 0; i < numCh; i++) begin
				totCntM[i] = 0;
				holdM[i] = 0;
			end
		end else begin
			stb = refStrobe(cntM, cfgM.downsample); // strobe seen before this edge
			for (int i = 0; i < numCh; i++)
				fireNext[i] = refFire(cfgM, inWinM[i], prevWinM[i], stb, totCntM[i]);
			for (int i = 0; i < numCh; i++) begin
				if (fireM[i]) holdM[i] = cfgM.holdTime; // window opens after fire
				else if (holdM[i] != 0 && stb) holdM[i]--;
			end
			if (selfM && deadM == 0) begin
				rateM++;
				deadM = cfgM.holdTime;
			end else if (deadM != 0 && stb) begin
				deadM--;
			end
			prevWinM = inWinM;
			for (int i = 0; i < numCh; i++)
				inWinM[i] = (sregM[i] >= cfgM.threshLo) && (sregM[i] <= cfgM.threshHi);
			sregM = samples;
			fireM = fireNext;
			cntM++;
			access = wbIn.cyc && wbIn.stb && !ackM;
			if (access && wbIn.we) begin
				case (wbIn.adr)
					regThresh: begin
						cfgM.threshLo = wbIn.dat[7:0];
						cfgM.threshHi = wbIn.dat[15:8];
					end
					regCtrl: begin
						cfgM.chanEn = wbIn.dat[3:0];
						cfgM.rising = wbIn.dat[4];
						cfgM.coincReq = wbIn.dat[6:5];
						cfgM.allowSameChan = wbIn.dat[7];
						cfgM.downsample = wbIn.dat[12:8];
					end
					regTot: begin
						cfgM.tot = wbIn.dat[totWidth-1:0];
						cfgM.totOnStrobe = wbIn.dat[31];
					end
					regHold: cfgM.holdTime = wbIn.dat[7:0];
					default: ; // rate and spare words are not writable
				endcase
			end
			ackM = access;
		end
		for (int j = 0; j < numCh; j++) held[j] = holdM[j] != 0;
		selfM = refSelfTrig(fireM, held, cfgM);
	endtask

	// outputs settle 1 ns after the edge while inputs still hold what it sampled
	always begin
		@(posedge clk_flash);
		#1;
		stepModel();
		assert (chanFire === fireM) else stopOnError($sformatf(
			"FAIL at %0t ns: chanFire is %b, expected %b", $time, chanFire, fireM));
		assert (selfEdgeTrig === selfM) else stopOnError($sformatf(
			"FAIL at %0t ns: selfEdgeTrig is %b, expected %b", $time, selfEdgeTrig, selfM));
		assert (trigRate === rateM) else stopOnError($sformatf(
			"FAIL at %0t ns: trigRate is %0d, expected %0d", $time, trigRate, rateM));
		assert (wbOut.ack === ackM) else stopOnError($sformatf(
			"FAIL at %0t ns: ack is %b, expected %b", $time, wbOut.ack, ackM));
	end

	always @(posedge clk_flash) begin
		cycles++;
		if (cycles >= cycleLimit)
			stopOnError($sformatf("timeout, the run went past %0d clock cycles", cycleLimit));
	end

	// classic handshake with the request held until ack
	task automatic busCycle(input logic we, input logic [wbAdrW-1:0] adr,
		input logic [wbDatW-1:0] dat, output logic [wbDatW-1:0] got);
		int waits;
		@(negedge clk_flash);
		wbIn = {1'b1, 1'b1, we, adr, dat}; // cyc, stb, we, adr, dat
		waits = 0;
		@(negedge clk_flash);
		while (!wbOut.ack) begin
			waits++;
			if (waits >= 4) stopOnError($sformatf("no Wishbone ack within 4 cycles at word %0d", adr));
			else @(negedge clk_flash);
		end
		got = wbOut.dat; // valid while ack is high
		wbIn = '0;
	endtask

	task automatic busWrite(input logic [wbAdrW-1:0] adr, input logic [wbDatW-1:0] dat);
		busCycle(1'b1, adr, dat, rdData);
	endtask

	task automatic checkRead(input logic [wbAdrW-1:0] adr, input logic [wbDatW-1:0] exp,
		input string what);
		busCycle(1'b0, adr, '0, rdData);
		assert (rdData === exp) else stopOnError($sformatf(
			"FAIL at %0t ns: %s read %h, expected %h", $time, what, rdData, exp));
	endtask

	task automatic checkCount(input int exp, input string what);
		assert (trigRate === rateWidth'(exp)) else stopOnError($sformatf(
			"FAIL at %0t ns: %s, trigRate is %0d, expected %0d", $time, what, trigRate, exp));
	endtask

	function automatic logic [wbDatW-1:0] ctrlWord(input logic [3:0] en, input logic rising,
		input logic [1:0] coinc, input logic sameChan, input logic [dsW-1:0] ds);
		return {19'b0, ds, sameChan, coinc, rising, en};
	endfunction

	function automatic logic [wbDatW-1:0] totWord(input int tot, input logic onStrobe);
		return {onStrobe, 21'b0, 10'(tot)};
	endfunction

	function automatic sample_t randIn();
		return sample_t'(loT + $urandom % (hiT - loT + 1));
	endfunction

	function automatic sample_t randOut();
		if ($urandom % 2) return sample_t'($urandom % loT); // below the window
		return sample_t'(hiT + 1 + $urandom % (255 - hiT)); // above it
	endfunction

	task automatic idle(input int n);
		repeat (n) @(negedge clk_flash);
	endtask

	// chosen channels inside the window for width cycles then outside
	task automatic pulse(input logic [numCh-1:0] which, input int width);
		@(negedge clk_flash);
		for (int ch = 0; ch < numCh; ch++)
			if (which[ch]) samples[ch] = randIn();
		idle(width);
		for (int ch = 0; ch < numCh; ch++)
			if (which[ch]) samples[ch] = randOut();
	endtask

	task automatic randomSteps(input int n);
		repeat (n) begin
			@(negedge clk_flash);
			for (int ch = 0; ch < numCh; ch++)
				if ($urandom % 3 == 0) samples[ch] = ($urandom % 2) ? randIn() : randOut();
		end
	endtask

	initial begin
		clk_flash = 1'b0;
		trigratecountreset = 1'b1;
		samples = '0;
		wbIn = '0;
		seedVar = 32'h2db7c9d5;
		void'($urandom(seedVar));
		idle(8);
		trigratecountreset = 1'b0;

		// register readback while samples stay at zero so nothing fires
		busWrite(regThresh, {16'h0, 8'(hiT), 8'(loT)});
		busWrite(regCtrl, 32'h0000_0af5);
		busWrite(regTot, 32'h8000_02a5);
		busWrite(regHold, 32'h0000_005a);
		checkRead(regThresh, {16'h0, 8'(hiT), 8'(loT)}, "threshold word");
		checkRead(regCtrl, 32'h0000_0af5, "control word");
		checkRead(regTot, 32'h8000_02a5, "tot word");
		checkRead(regHold, 32'h0000_005a, "hold word");
		busWrite(regRate, 32'hdead_beef); // read only
		checkRead(regRate, 32'h0, "rate word after write");
		checkRead(3'd5, 32'h0, "unused word");

		// plain edges without hold windows or triggers
		busWrite(regHold, 32'h0);
		busWrite(regTot, totWord(0, 1'b0));
		busWrite(regCtrl, ctrlWord(4'h0, 1'b1, 2'd0, 1'b0, 5'd0));
		randomSteps(200);
		busWrite(regCtrl, ctrlWord(4'h0, 1'b0, 2'd0, 1'b0, 5'd0)); // falling
		randomSteps(200);

		// time over threshold per clock and then per strobe
		busWrite(regCtrl, ctrlWord(4'h0, 1'b1, 2'd0, 1'b0, 5'd0));
		busWrite(regTot, totWord(3, 1'b0));
		repeat (30) begin
			pulse(4'hf, 1 + $urandom % 8);
			idle(1 + $urandom % 6);
		end
		busWrite(regCtrl, ctrlWord(4'h0, 1'b1, 2'd0, 1'b0, 5'd2));
		busWrite(regTot, totWord(3, 1'b1));
		repeat (30) begin
			pulse(4'hf, 1 + $urandom % 20);
			idle(1 + $urandom % 8);
		end

		// coincidence of channels 0 and 1
		busWrite(regTot, totWord(0, 1'b0));
		busWrite(regHold, 32'd10);
		busWrite(regCtrl, ctrlWord(4'b0011, 1'b1, 2'd1, 1'b0, 5'd0));
		idle(20);
		pulse(4'b0001, 2);
		idle(1);
		pulse(4'b0001, 2); // own window is open but does not count
		idle(15);
		checkCount(0, "lone channel");
		pulse(4'b0001, 2);
		idle(1);
		pulse(4'b0010, 2); // inside the channel 0 hold window
		idle(15);
		checkCount(1, "two channel coincidence");
		busWrite(regCtrl, ctrlWord(4'b0011, 1'b1, 2'd1, 1'b1, 5'd0));
		pulse(4'b0001, 2);
		idle(1);
		pulse(4'b0001, 2); // own window still open
		idle(15);
		checkCount(2, "same channel twice");

		// dead time of 20 strobes with a strobe every second cycle
		busWrite(regHold, 32'd20);
		busWrite(regCtrl, ctrlWord(4'b0001, 1'b1, 2'd0, 1'b0, 5'd1));
		repeat (3) begin
			pulse(4'b0001, 2);
			idle(60);
		end
		checkCount(5, "isolated triggers");
		pulse(4'b0001, 2);
		idle(4);
		pulse(4'b0001, 2); // lands in the dead time
		idle(60);
		checkCount(6, "trigger inside dead time");
		checkRead(regRate, 32'd6, "rate word");
		@(negedge clk_flash);
		trigratecountreset = 1'b1;
		idle(8);
		trigratecountreset = 1'b0;
		checkCount(0, "after reset");
		idle(5);
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* trigConfigRegs.sv */
`timescale 1ns/10ps

module trigConfigRegs import oscTrigPkg::*; #(
	parameter int totWidth = 10,
	parameter int rateWidth = 32
) (
	input logic clk_flash,
	input logic trigratecountreset,
	input wbReq_t wbIn,
	output wbResp_t wbOut,
	input logic [rateWidth-1:0] rateCount,
	output trigCfg_t cfg
);

	logic ackReg; // one cycle acknowledge
	logic [wbDatW-1:0] datReg; // read data held while ack is high
	logic [wbDatW-1:0] readData; // addressed register contents
	logic access; // new bus cycle this clock

	assign access = wbIn.cyc && wbIn.stb && !ackReg; // ack low last cycle, so this is a fresh request

	// read mux, unused addresses and bits return zero
	always_comb begin
		readData = '0;
		case (wbIn.adr)
			regThresh: readData[2*sampleW-1:0] = {cfg.threshHi, cfg.threshLo};
			regCtrl: readData[8+dsW-1:0] = {cfg.downsample, cfg.allowSameChan,
				cfg.coincReq, cfg.rising, cfg.chanEn};
			regTot: begin
				readData[totWidth-1:0] = cfg.tot[totWidth-1:0];
				readData[wbDatW-1] = cfg.totOnStrobe;
			end
			regHold: readData[holdW-1:0] = cfg.holdTime;
			regRate: readData[rateWidth-1:0] = rateCount; // live count
			default: readData = '0;
		endcase
	end

	always_ff @(posedge clk_flash) begin
		if (trigratecountreset) begin
			ackReg <= 1'b0;
			datReg <= '0;
			cfg <= '0; // all channels disabled, strobe every cycle
		end else begin
			ackReg <= access;
			if (access) begin
				datReg <= readData; // sampled on the ack edge
				if (wbIn.we) begin
					case (wbIn.adr)
						regThresh: begin
							cfg.threshLo <= wbIn.dat[sampleW-1:0];
							cfg.threshHi <= wbIn.dat[2*sampleW-1:sampleW];
						end
						regCtrl: begin
							cfg.chanEn <= wbIn.dat[3:0];
							cfg.rising <= wbIn.dat[4];
							cfg.coincReq <= wbIn.dat[6:5];
							cfg.allowSameChan <= wbIn.dat[7];
							cfg.downsample <= wbIn.dat[8+dsW-1:8];
						end
						regTot: begin
							cfg.tot <= totMax'(wbIn.dat[totWidth-1:0]); // upper bits stay zero
							cfg.totOnStrobe <= wbIn.dat[wbDatW-1];
						end
						regHold: cfg.holdTime <= wbIn.dat[holdW-1:0];
						default: ; // rate and unused words ignore writes
					endcase
				end
			end
		end
	end

	assign wbOut = '{ack: ackReg, dat: datReg};

endmodule

/* trigRateCounter.sv */
`timescale 1ns/10ps

module trigRateCounter import oscTrigPkg::*; #(
	parameter int rateWidth = 32
) (
	input logic clk_flash,
	input logic trigratecountreset,
	input logic selfEdgeTrig,
	input logic [holdW-1:0] holdTime,
	input logic strobe,
	output logic [rateWidth-1:0] rateCount
);

	logic [holdW-1:0] deadTime; // strobes left before the next trigger counts

	always_ff @(posedge clk_flash) begin
		if (trigratecountreset) begin
			rateCount <= '0;
			deadTime <= '0;
		end else if (selfEdgeTrig && deadTime == '0) begin
			rateCount <= rateCount + 1'b1; // accepted trigger
			deadTime <= holdTime; // same length as the hold window
		end else if (deadTime != '0 && strobe) begin
			deadTime <= deadTime - 1'b1;
		end
	end

endmodule
